// File: verilog/dbg_pkg.sv
package dbg_pkg;

    // ==================================================
    // apb register offsets
    // ==================================================
    localparam logic [11:0] DBG_EN_ADDR       = 12'h000;
    localparam logic [11:0] DBG_CMD_ADDR      = 12'h004;
    localparam logic [11:0] DBG_CMD_GO_ADDR   = 12'h008;
    localparam logic [11:0] DBG_WDATA_L_ADDR  = 12'h010;
    localparam logic [11:0] DBG_WDATA_H_ADDR  = 12'h014;
    localparam logic [11:0] DBG_WDATA_WR_ADDR = 12'h018;
    localparam logic [11:0] DBG_RDATA_L_ADDR  = 12'h020;
    localparam logic [11:0] DBG_RDATA_H_ADDR  = 12'h024;

    // command code, low 12 bits of the command word
    typedef enum logic [11:0] {
        CMD_ATTACH    = 12'h001,
        CMD_RESUME    = 12'h002,
        CMD_EXECUTE   = 12'h004,
        CMD_STATUS_RD = 12'h010,
        CMD_PC_RD     = 12'h020,
        CMD_GPR_RD    = 12'h040,
        CMD_GPR_WR    = 12'h080,
        CMD_CSR_RD    = 12'h100,
        CMD_CSR_WR    = 12'h200
    } dbg_cmd_e;

    localparam logic [11:0] CSR_MISA     = 12'h301;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;

    localparam logic [31:0] MISA_VALUE = 32'h4000_0100; // rv32i
    localparam logic [31:0] RESET_PC   = 32'h0000_1000;

    // pready wait states per command
    localparam logic [9:0] READY_WAIT_EXEC   = 10'd5;
    localparam logic [9:0] READY_WAIT_CSR_WR = 10'd2;
    localparam logic [9:0] READY_WAIT_ACCESS = 10'd1;
    localparam logic [9:0] READY_WAIT_CTRL   = 10'd0;

endpackage

// File: verilog/dbg_apb_regs.sv
`timescale 1ns/10ps

module dbg_apb_regs import dbg_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [11:0]     paddr,
    input  logic [31:0]     pwdata,
    input  logic [XLEN-1:0] rdata,
    output logic [31:0]     prdata,
    output logic            pready,
    output logic            pslverr,
    output logic            cmd_go,
    output logic [31:0]     cmd,
    output logic            wdata_ld,
    output logic [XLEN-1:0] wdata
);

    logic        dbg_en;
    logic        apb_wr;
    logic        en_wr;          // write accepted while enabled
    logic [31:0] wdata_l;
    logic [31:0] wdata_h;
    logic [31:0] rdata_h;
    logic [31:0] rd_mux;
    logic [9:0]  nxt_ready_cnt;
    logic [9:0]  ready_cnt;

    assign apb_wr = psel && !penable && pwrite; // setup phase
    assign en_wr  = apb_wr && dbg_en;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dbg_en <= 1'b0;
        end else if (apb_wr && paddr == DBG_EN_ADDR) begin
            dbg_en <= pwdata[0];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cmd      <= '0;
            wdata_l  <= '0;
            cmd_go   <= 1'b0;
            wdata_ld <= 1'b0;
        end else begin
            cmd_go   <= en_wr && paddr == DBG_CMD_GO_ADDR;
            wdata_ld <= en_wr && paddr == DBG_WDATA_WR_ADDR;
            if (en_wr && paddr == DBG_CMD_ADDR) cmd <= pwdata;
            if (en_wr && paddr == DBG_WDATA_L_ADDR) wdata_l <= pwdata;
        end
    end

    // ==================================================
    // upper data halves, rv64 only
    // ==================================================
    generate
        if (XLEN == 64) begin : g_xlen64
            always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                    wdata_h <= '0;
                end else if (en_wr && paddr == DBG_WDATA_H_ADDR) begin
                    wdata_h <= pwdata;
                end
            end
            assign wdata   = {wdata_h, wdata_l};
            assign rdata_h = rdata[XLEN-1 -: 32];
        end else begin : g_xlen32
            assign wdata_h = '0;
            assign wdata   = wdata_l;
            assign rdata_h = '0;
        end
    endgenerate

    always_comb begin
        rd_mux = '0;
        case (paddr)
            DBG_EN_ADDR:      rd_mux = {31'b0, dbg_en};
            DBG_CMD_ADDR:     rd_mux = cmd;
            DBG_WDATA_L_ADDR: rd_mux = wdata_l;
            DBG_WDATA_H_ADDR: rd_mux = wdata_h;
            DBG_RDATA_L_ADDR: rd_mux = rdata[31:0];
            DBG_RDATA_H_ADDR: rd_mux = rdata_h;
            default:          rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prdata <= '0;
        end else if (dbg_en || paddr == DBG_EN_ADDR) begin
            prdata <= rd_mux;
        end else begin
            prdata <= '0;  // hidden while disabled
        end
    end

    // ==================================================
    // pready stretch after a go write
    // ==================================================
    always_comb begin
        nxt_ready_cnt = '0;
        if (en_wr && paddr == DBG_CMD_GO_ADDR) begin
            case (cmd[11:0])
                CMD_EXECUTE:   nxt_ready_cnt = READY_WAIT_EXEC;
                CMD_CSR_WR:    nxt_ready_cnt = READY_WAIT_CSR_WR;
                CMD_STATUS_RD,
                CMD_PC_RD,
                CMD_GPR_RD,
                CMD_GPR_WR,
                CMD_CSR_RD:    nxt_ready_cnt = READY_WAIT_ACCESS;
                CMD_ATTACH,
                CMD_RESUME:    nxt_ready_cnt = READY_WAIT_CTRL;
                default:       nxt_ready_cnt = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ready_cnt <= '0;
        end else if (apb_wr) begin
            ready_cnt <= nxt_ready_cnt;
        end else if (|ready_cnt) begin
            ready_cnt <= ready_cnt - 10'd1;
        end
    end

    assign pready  = ~|ready_cnt;
    assign pslverr = 1'b0;

    // wait states only ever land inside an access phase
    a_pready_in_access: assert property (
        @(posedge clk) disable iff (!rstn) !pready |-> (psel && penable)
    );

endmodule

// File: verilog/dbg_cmd_exec.sv
`timescale 1ns/10ps

module dbg_cmd_exec import dbg_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            cmd_go,
    input  logic [31:0]     cmd,
    input  logic            wdata_ld,
    input  logic [XLEN-1:0] wdata,
    input  logic [XLEN-1:0] gpr_rdata,
    input  logic [XLEN-1:0] csr_rdata,
    input  logic [XLEN-1:0] pc,
    input  logic            halted,
    output logic [11:0]     reg_addr,
    output logic [XLEN-1:0] reg_wdata,
    output logic            gpr_rd,
    output logic            gpr_wr,
    output logic            csr_rd,
    output logic            csr_wr,
    output logic            attach_req,
    output logic            resume_req,
    output logic            exec,
    output logic [XLEN-1:0] rdata
);

    logic            pc_rd;
    logic            status_sel;
    logic            attached;
    logic [XLEN-1:0] result;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            reg_wdata <= '0;
        end else if (wdata_ld) begin
            reg_wdata <= wdata;
        end
    end

    // ==================================================
    // decode into one-cycle strobes
    // ==================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            reg_addr   <= '0;
            status_sel <= 1'b0;
            pc_rd      <= 1'b0;
            gpr_rd     <= 1'b0;
            gpr_wr     <= 1'b0;
            csr_rd     <= 1'b0;
            csr_wr     <= 1'b0;
            attach_req <= 1'b0;
            resume_req <= 1'b0;
            exec       <= 1'b0;
        end else begin
            pc_rd      <= 1'b0;
            gpr_rd     <= 1'b0;
            gpr_wr     <= 1'b0;
            csr_rd     <= 1'b0;
            csr_wr     <= 1'b0;
            attach_req <= 1'b0;
            resume_req <= 1'b0;
            exec       <= 1'b0;
            if (cmd_go) begin
                reg_addr <= cmd[27:16];
                case (cmd[11:0])
                    CMD_ATTACH:    attach_req <= 1'b1;
                    CMD_RESUME:    resume_req <= 1'b1;
                    CMD_EXECUTE:   exec <= 1'b1;
                    CMD_STATUS_RD: status_sel <= 1'b1;
                    CMD_PC_RD: begin
                        status_sel <= 1'b0;
                        pc_rd      <= 1'b1;
                    end
                    CMD_GPR_RD: begin
                        status_sel <= 1'b0;
                        gpr_rd     <= 1'b1;
                    end
                    CMD_CSR_RD: begin
                        status_sel <= 1'b0;
                        csr_rd     <= 1'b1;
                    end
                    CMD_GPR_WR:    gpr_wr <= 1'b1;
                    CMD_CSR_WR:    csr_wr <= 1'b1;
                    default: ;     // unknown code, no action
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            attached <= 1'b0;
        end else if (attach_req) begin
            attached <= 1'b1;
        end else if (resume_req) begin
            attached <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            result <= '0;
        end else if (pc_rd) begin
            result <= pc;
        end else if (gpr_rd) begin
            result <= gpr_rdata;
        end else if (csr_rd) begin
            result <= csr_rdata;
        end
    end

    assign rdata = status_sel ? {{(XLEN-2){1'b0}}, halted, attached} : result;

    a_strobe_onehot: assert property (
        @(posedge clk) disable iff (!rstn) $onehot0({pc_rd, gpr_rd, gpr_wr, csr_rd, csr_wr})
    );

endmodule

// File: verilog/gpr_file.sv
`timescale 1ns/10ps

module gpr_file #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic [11:0]     reg_addr,
    input  logic [XLEN-1:0] reg_wdata,
    input  logic            gpr_rd,
    input  logic            gpr_wr,
    output logic [XLEN-1:0] gpr_rdata
);

    logic [XLEN-1:0] regs [32];
    logic [4:0]      idx;

    assign idx = reg_addr[4:0];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (gpr_wr && idx != 5'd0) begin
            regs[idx] <= reg_wdata; // x0 stays zero
        end
    end

    assign gpr_rdata = (gpr_rd && idx != 5'd0) ? regs[idx] : '0;

    // the command stage never reads and writes in one cycle
    a_no_rd_wr: assert property (
        @(posedge clk) disable iff (!rstn) !(gpr_rd && gpr_wr)
    );

endmodule

// File: verilog/csr_file.sv
`timescale 1ns/10ps

module csr_file import dbg_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic [11:0]     reg_addr,
    input  logic [XLEN-1:0] reg_wdata,
    input  logic            csr_rd,
    input  logic            csr_wr,
    output logic [XLEN-1:0] csr_rdata
);

    localparam logic [XLEN-1:0] MTVEC_MASK = ~XLEN'(2); // bit 1 reserved

    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
        end else if (csr_wr) begin
            case (reg_addr)
                CSR_MTVEC:    mtvec <= reg_wdata & MTVEC_MASK;
                CSR_MSCRATCH: mscratch <= reg_wdata;
                CSR_MEPC:     mepc <= reg_wdata;
                default: ;    // misa and unmapped are read-only
            endcase
        end
    end

    always_comb begin
        csr_rdata = '0;
        if (csr_rd) begin
            case (reg_addr)
                CSR_MISA:     csr_rdata = XLEN'(MISA_VALUE);
                CSR_MTVEC:    csr_rdata = mtvec;
                CSR_MSCRATCH: csr_rdata = mscratch;
                CSR_MEPC:     csr_rdata = {mepc[XLEN-1:2], 2'b00};
                default:      csr_rdata = '0;
            endcase
        end
    end

endmodule

// File: verilog/hart_ctrl.sv
`timescale 1ns/10ps

module hart_ctrl import dbg_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            attach_req,
    input  logic            resume_req,
    input  logic            exec,
    output logic            halted,
    output logic [XLEN-1:0] pc
);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            halted <= 1'b0;
        end else if (attach_req) begin
            halted <= 1'b1;
        end else if (resume_req) begin
            halted <= 1'b0;
        end
    end

    // free run, or one step per exec while halted
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc <= XLEN'(RESET_PC);
        end else if (!halted || exec) begin
            pc <= pc + XLEN'(4);
        end
    end

endmodule

// File: verilog/dbg_sys_top.sv
`timescale 1ns/10ps

module dbg_sys_top #(
    parameter int XLEN = 32
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic            cmd_go;
    logic [31:0]     cmd;
    logic            wdata_ld;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;
    logic [11:0]     reg_addr;
    logic [XLEN-1:0] reg_wdata;
    logic            gpr_rd;
    logic            gpr_wr;
    logic            csr_rd;
    logic            csr_wr;
    logic [XLEN-1:0] gpr_rdata;
    logic [XLEN-1:0] csr_rdata;
    logic            attach_req;
    logic            resume_req;
    logic            exec;
    logic            halted;
    logic [XLEN-1:0] pc;

    dbg_apb_regs #(.XLEN(XLEN)) u_apb_regs (
        .clk(clk), .rstn(rstn),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .rdata(rdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .cmd_go(cmd_go), .cmd(cmd), .wdata_ld(wdata_ld), .wdata(wdata)
    );

    dbg_cmd_exec #(.XLEN(XLEN)) u_cmd_exec (
        .clk(clk), .rstn(rstn),
        .cmd_go(cmd_go), .cmd(cmd), .wdata_ld(wdata_ld), .wdata(wdata),
        .gpr_rdata(gpr_rdata), .csr_rdata(csr_rdata), .pc(pc), .halted(halted),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .gpr_rd(gpr_rd), .gpr_wr(gpr_wr), .csr_rd(csr_rd), .csr_wr(csr_wr),
        .attach_req(attach_req), .resume_req(resume_req), .exec(exec), .rdata(rdata)
    );

    gpr_file #(.XLEN(XLEN)) u_gpr (
        .clk(clk), .rstn(rstn), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .gpr_rd(gpr_rd), .gpr_wr(gpr_wr), .gpr_rdata(gpr_rdata)
    );

    csr_file #(.XLEN(XLEN)) u_csr (
        .clk(clk), .rstn(rstn), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .csr_rd(csr_rd), .csr_wr(csr_wr), .csr_rdata(csr_rdata)
    );

    hart_ctrl #(.XLEN(XLEN)) u_hart (
        .clk(clk), .rstn(rstn), .attach_req(attach_req), .resume_req(resume_req),
        .exec(exec), .halted(halted), .pc(pc)
    );

endmodule

// File: tests/tb_dbg_sys.sv
`timescale 1ns/10ps

module tb_dbg_sys import dbg_pkg::*; ();

    typedef enum int {
        OP_WR, OP_RD, OP_STATUS,
        OP_PC_SAVE, OP_PC_STEP, OP_PC_MOVED
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [11:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
    } step_t;

    logic        clk;
    logic        rstn;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    step_t       steps[$];
    integer      seed = 88;
    logic [31:0] pc_ref;        // expected pc while halted
    int          cycles = 0;
    int          cycle_limit = 0;
    int          checks = 0;
    int          data_errors = 0;
    int          bus_errors = 0;

    dbg_sys_top #(.XLEN(32)) UUT (
        .clk(clk), .rstn(rstn),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the test did not finish within %0d clock cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ==================================================
    // stimulus table
    // ==================================================
    function automatic void push_step(op_e op, logic [11:0] addr, logic [31:0] data,
                                      logic [31:0] exp);
        step_t s;
        s.op   = op;
        s.addr = addr;
        s.data = data;
        s.exp  = exp;
        steps.push_back(s);
    endfunction

    // command word, then go
    function automatic void issue_cmd(dbg_cmd_e code, logic [11:0] ra);
        push_step(OP_WR, DBG_CMD_ADDR, {4'h0, ra, 4'h0, code}, '0);
        push_step(OP_WR, DBG_CMD_GO_ADDR, 32'h1, '0);
    endfunction

    function automatic void stage_wdata(logic [31:0] value);
        push_step(OP_WR, DBG_WDATA_L_ADDR, value, '0);
        push_step(OP_WR, DBG_WDATA_WR_ADDR, 32'h1, '0);
    endfunction

    function automatic void csr_roundtrip(logic [11:0] csr, logic [31:0] value,
                                          logic [31:0] exp);
        stage_wdata(value);
        issue_cmd(CMD_CSR_WR, csr);
        issue_cmd(CMD_CSR_RD, csr);
        push_step(OP_RD, DBG_RDATA_L_ADDR, '0, exp);
    endfunction

    function automatic void build_table();
        logic [31:0] val;
        logic [31:0] cmd_word;
        // disabled, everything but the enable register is dropped
        stage_wdata($random(seed));
        issue_cmd(CMD_GPR_WR, 12'd5);
        push_step(OP_RD, DBG_CMD_ADDR, '0, 32'h0);
        push_step(OP_RD, DBG_WDATA_L_ADDR, '0, 32'h0);
        push_step(OP_RD, DBG_RDATA_L_ADDR, '0, 32'h0);
        push_step(OP_RD, DBG_EN_ADDR, '0, 32'h0);
        push_step(OP_WR, DBG_EN_ADDR, 32'h1, '0);
        push_step(OP_RD, DBG_EN_ADDR, '0, 32'h1);
        push_step(OP_RD, DBG_CMD_ADDR, '0, 32'h0);
        cmd_word = {4'h0, 12'd5, 4'h0, CMD_GPR_RD};
        issue_cmd(CMD_GPR_RD, 12'd5);
        push_step(OP_RD, DBG_CMD_ADDR, '0, cmd_word);
        push_step(OP_RD, DBG_RDATA_L_ADDR, '0, 32'h0);  // x5 never written
        // disabled again, held command hidden and go dropped
        cmd_word = {4'h0, 12'd0, 4'h0, CMD_ATTACH};
        push_step(OP_WR, DBG_CMD_ADDR, cmd_word, '0);
        push_step(OP_WR, DBG_EN_ADDR, 32'h0, '0);
        push_step(OP_WR, DBG_CMD_GO_ADDR, 32'h1, '0);
        push_step(OP_RD, DBG_CMD_ADDR, '0, 32'h0);
        push_step(OP_WR, DBG_EN_ADDR, 32'h1, '0);
        push_step(OP_RD, DBG_CMD_ADDR, '0, cmd_word);
        // gpr
        val = $random(seed);
        stage_wdata(val);
        push_step(OP_RD, DBG_WDATA_L_ADDR, '0, val);
        issue_cmd(CMD_GPR_WR, 12'd7);
        issue_cmd(CMD_GPR_RD, 12'd7);
        push_step(OP_RD, DBG_RDATA_L_ADDR, '0, val);
        stage_wdata($random(seed));
        issue_cmd(CMD_GPR_WR, 12'd0);
        issue_cmd(CMD_GPR_RD, 12'd0);
        push_step(OP_RD, DBG_RDATA_L_ADDR, '0, 32'h0);
        // csr
        val = $random(seed);
        csr_roundtrip(CSR_MSCRATCH, val, val);
        val = $random(seed);
        csr_roundtrip(CSR_MTVEC, val, val & ~32'h2);
        val = $random(seed);
        csr_roundtrip(CSR_MEPC, val, val & ~32'h3);
        csr_roundtrip(CSR_MISA, $random(seed), MISA_VALUE);
        csr_roundtrip(12'h7c0, $random(seed), 32'h0);   // unmapped
        // halt, step, resume
        issue_cmd(CMD_STATUS_RD, 12'd0);
        push_step(OP_STATUS, DBG_RDATA_L_ADDR, '0, 32'h0);
        issue_cmd(CMD_ATTACH, 12'd0);
        issue_cmd(CMD_STATUS_RD, 12'd0);
        push_step(OP_STATUS, DBG_RDATA_L_ADDR, '0, 32'h3);
        issue_cmd(CMD_PC_RD, 12'd0);
        push_step(OP_PC_SAVE, DBG_RDATA_L_ADDR, '0, '0);
        issue_cmd(CMD_PC_RD, 12'd0);
        push_step(OP_PC_STEP, DBG_RDATA_L_ADDR, 32'd0, '0);
        for (int i = 0; i < 2; i++) begin
            issue_cmd(CMD_EXECUTE, 12'd0);
            issue_cmd(CMD_PC_RD, 12'd0);
            push_step(OP_PC_STEP, DBG_RDATA_L_ADDR, 32'd4, '0);
        end
        issue_cmd(CMD_RESUME, 12'd0);
        issue_cmd(CMD_STATUS_RD, 12'd0);
        push_step(OP_STATUS, DBG_RDATA_L_ADDR, '0, 32'h0);
        issue_cmd(CMD_PC_RD, 12'd0);
        push_step(OP_PC_MOVED, DBG_RDATA_L_ADDR, '0, '0);
    endfunction

    // ==================================================
    // apb master and checks
    // ==================================================
    task automatic wait_ready(input logic [11:0] addr);
        @(negedge clk);
        while (!pready) @(negedge clk);
        if (pslverr !== 1'b0) begin
            bus_errors++;
            $display("error @%0t: pslverr set on access to 0x%03h", $time, addr);
        end
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        wait_ready(addr);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        wait_ready(addr);
        data = prdata;      // mid-cycle, stable
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            data_errors++;
            $display("error @%0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input logic [31:0] got, input logic exp_halted,
                                input logic exp_attached, input string what);
        checks++;
        if (got[1] !== exp_halted || got[0] !== exp_attached || got[31:2] !== '0) begin
            data_errors++;
            $display("error @%0t: %s status 0x%08h, expected halted %b attached %b",
                     $time, what, got, exp_halted, exp_attached);
        end
    endtask

    task automatic run_step(input int idx);
        step_t       s;
        logic [31:0] got;
        string       what;
        s    = steps[idx];
        what = $sformatf("step %0d addr 0x%03h", idx, s.addr);
        case (s.op)
            OP_WR: apb_write(s.addr, s.data);
            OP_RD: begin
                apb_read(s.addr, got);
                check_rdata(got, s.exp, what);
            end
            OP_STATUS: begin
                apb_read(s.addr, got);
                check_status(got, s.exp[1], s.exp[0], what);
            end
            OP_PC_SAVE: begin
                apb_read(s.addr, got);
                check_rdata({30'b0, got[1:0]}, 32'h0, what);  // word aligned
                checks++;
                if (got < pc_ref || got - pc_ref > 32'(4 * cycles)) begin
                    data_errors++;
                    $display("error @%0t: %s pc 0x%08h not reachable from reset pc 0x%08h",
                             $time, what, got, pc_ref);
                end
                pc_ref = got;
            end
            OP_PC_STEP: begin
                apb_read(s.addr, got);
                pc_ref = pc_ref + s.data;
                check_rdata(got, pc_ref, what);
            end
            OP_PC_MOVED: begin
                apb_read(s.addr, got);
                checks++;
                if (got === pc_ref) begin
                    data_errors++;
                    $display("error @%0t: %s pc still 0x%08h after resume", $time, what, got);
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        rstn    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        pc_ref  = RESET_PC;
        build_table();
        cycle_limit = 20 * steps.size() + 100;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            run_step(i);
        end
        repeat (2) @(posedge clk);
        $display("checks %0d, data errors %0d, bus errors %0d",
                 checks, data_errors, bus_errors);
        if (data_errors == 0 && bus_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: dbg_sys.f
verilog/dbg_pkg.sv
verilog/dbg_apb_regs.sv
verilog/dbg_cmd_exec.sv
verilog/gpr_file.sv
verilog/csr_file.sv
verilog/hart_ctrl.sv
verilog/dbg_sys_top.sv
tests/tb_dbg_sys.sv
